// ==== src.f ====
exe_pkg.sv
regfile.sv
alu.sv
issue_stage.sv
exe_stage.sv
wb_stage.sv
exe_pipe_top.sv
tb_exe_pipe.sv

// ==== Bender.yml ====
package:
  name: exe_pipe

sources:
  - exe_pkg.sv
  - regfile.sv
  - alu.sv
  - issue_stage.sv
  - exe_stage.sv
  - wb_stage.sv
  - exe_pipe_top.sv
  - target: simulation
    files:
      - tb_exe_pipe.sv

// ==== tb_exe_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_pipe;

    import exe_pkg::*;

    localparam int MAX_CYCLES = 2000;   // directed tests take about 400

    // one expected retirement
    typedef struct packed {
        logic [REG_IDX_W-1:0] rd_idx;
        logic [XLEN-1:0]      data;
        logic                 written;
        logic                 illegal;
        logic [31:0]          cyc;        // cycle the slot was accepted
        logic [31:0]          stalls;     // stall count at acceptance
    } exp_t;

    // redirect expected from one issue slot
    typedef struct packed {
        logic            redir;
        logic [XLEN-1:0] pc;
    } redir_t;

    logic            clk;
    logic            rst_n;
    logic            stall;
    dec_t            dec;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    retire_t         retire;

    logic [XLEN-1:0] mregs [NUM_REGS];   // architectural register model
    exp_t            exp_q [$];          // in-order retire expectations
    redir_t          iss_m;              // model of the ID/EX slot
    redir_t          hold_m;             // redirect seen in last unstalled cycle
    int              ncyc       = 0;
    int              stall_cnt  = 0;
    int              run_cycles = 0;
    integer          seed;
    logic [XLEN-1:0] pc_q;

    initial clk = 1'b0;
    always #5 clk = ~clk;                // 10 ns period

    exe_pipe_top i_dut (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n       ),
        .stall_i       ( stall       ),
        .dec_i         ( dec         ),
        .redirect_o    ( redirect    ),
        .redirect_pc_o ( redirect_pc ),
        .retire_o      ( retire      )
    );

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ========================================
    // random helpers and instruction builders
    // ========================================
    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [XLEN-1:0] r;
        r = rand_word();
        return int'(r[30:0] % n);
    endfunction

    function automatic logic [REG_IDX_W-1:0] rand_reg();
        return REG_IDX_W'(1 + rand_below(NUM_REGS - 1));    // never x0
    endfunction

    function automatic alu_op_e rand_alu_op();
        return alu_op_e'(rand_below(10));                   // ADD .. SLTU
    endfunction

    function automatic dec_t alu_instr(input alu_op_e op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic use_imm, input logic [XLEN-1:0] imm);
        dec_t d;
        d         = '0;
        d.valid   = 1'b1;
        d.op      = op;
        d.rs1_idx = rs1;
        d.rs2_idx = rs2;
        d.use_imm = use_imm;
        d.imm     = imm;
        d.res_src = RES_ALU;
        d.rd_idx  = rd;
        d.reg_we  = 1'b1;
        return d;
    endfunction

    function automatic dec_t li_instr(input logic [4:0] rd, input logic [XLEN-1:0] val);
        dec_t d;
        d         = alu_instr(OP_AND, rd, 5'd0, 5'd0, 1'b1, val);  // alu side gives zero
        d.res_src = RES_IMM;    // lui style
        return d;
    endfunction

    function automatic dec_t branch_instr(input alu_op_e op, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic pred);
        dec_t            d;
        logic [XLEN-1:0] tgt;
        tgt          = rand_word();
        d            = alu_instr(op, 5'd0, rs1, rs2, 1'b0, '0);
        d.reg_we     = 1'b0;
        d.is_branch  = 1'b1;
        d.pred_taken = pred;
        d.target_pc  = {tgt[XLEN-1:2], 2'b00};   // word aligned
        return d;
    endfunction

    function automatic dec_t jalr_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [XLEN-1:0] imm, input logic pred);
        dec_t d;
        d            = alu_instr(OP_ADD, rd, rs1, 5'd0, 1'b1, imm);
        d.is_jalr    = 1'b1;
        d.pred_taken = pred;
        d.res_src    = RES_PC4;   // link value
        return d;
    endfunction

    function automatic dec_t rand_instr();
        if (rand_below(5) == 0) begin
            return branch_instr(alu_op_e'(OP_BEQ + rand_below(6)), rand_reg(), rand_reg(),
                                1'(rand_below(2)));
        end
        return alu_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(),
                         1'(rand_below(2)), rand_word());
    endfunction

    // ========================================
    // rv32i reference model
    // ========================================
    function automatic logic [XLEN-1:0] ref_result(input alu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;                 // branch codes give zero
        endcase
    endfunction

    function automatic logic ref_taken(input alu_op_e op, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // executes one accepted slot in program order
    task automatic model_accept(input dec_t d);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            taken;
        exp_t            e;
        a     = mregs[d.rs1_idx];                      // mregs[0] stays zero
        b     = d.use_imm ? d.imm : mregs[d.rs2_idx];
        res   = ref_result(d.op, a, b);
        taken = ref_taken(d.op, a, b);
        case (d.res_src)
            RES_IMM: e.data = d.imm;
            RES_PC4: e.data = d.pc_plus4;
            default: e.data = res;
        endcase
        e.rd_idx  = d.rd_idx;
        e.written = d.reg_we && !d.illegal && (d.rd_idx != '0);
        e.illegal = d.illegal;
        e.cyc     = ncyc;
        e.stalls  = stall_cnt;
        if (e.written) begin
            mregs[d.rd_idx] = e.data;
        end
        exp_q.push_back(e);
        iss_m = '0;
        if (d.is_jalr) begin
            iss_m.redir = !d.pred_taken;
            iss_m.pc    = {res[XLEN-1:1], 1'b0};
        end else if (d.is_branch) begin
            iss_m.redir = d.pred_taken ^ taken;
            iss_m.pc    = taken ? d.target_pc : d.pc_plus4;
        end
    endtask

    // ========================================
    // monitor sampling mid-cycle
    // ========================================
    always @(negedge clk) begin : monitor
        exp_t e;
        if (rst_n) begin
            ncyc++;
            if (stall) begin
                stall_cnt++;
                check_val("retire_o.valid", retire.valid, 1'b0);
                check_val("redirect_o", redirect, hold_m.redir);     // replayed
                if (hold_m.redir) begin
                    check_val("redirect_pc_o", redirect_pc, hold_m.pc);
                end
            end else begin
                check_val("redirect_o", redirect, iss_m.redir);
                if (iss_m.redir) begin
                    check_val("redirect_pc_o", redirect_pc, iss_m.pc);
                end
                hold_m = iss_m;
                if (retire.valid) begin
                    if (exp_q.size() == 0) begin
                        check_val("retire_o.valid", 1'b1, 1'b0);   // nothing outstanding
                    end
                    e = exp_q.pop_front();
                    check_val("retire_o.rd_idx", retire.rd_idx, e.rd_idx);
                    check_val("retire_o.data", retire.data, e.data);
                    check_val("retire_o.written", retire.written, e.written);
                    check_val("retire_o.illegal", retire.illegal, e.illegal);
                    check_val("retire latency", ncyc - e.cyc, 2 + stall_cnt - e.stalls);
                end
                if (dec.valid && !iss_m.redir) begin
                    model_accept(dec);
                end else begin
                    iss_m = '0;     // empty or flushed slot
                end
            end
        end
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests never finished", run_cycles);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // ========================================
    // drivers
    // ========================================
    task automatic send(input dec_t d);
        @(posedge clk);
        d.pc_plus4 = pc_q + 4;
        pc_q       = pc_q + 4;
        stall <= 1'b0;
        dec   <= d;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            stall <= 1'b0;
            dec   <= '0;
        end
    endtask

    task automatic stall_for(input int n);
        repeat (n) begin
            @(posedge clk);
            stall <= 1'b1;
            dec   <= li_instr(5'd29, 32'hbad3_0000);   // must be ignored
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(2);    // catches stray retirements
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset();
        @(negedge clk);
        check_val("redirect_o", redirect, 1'b0);
        check_val("retire_o.valid", retire.valid, 1'b0);
        send(alu_instr(OP_ADD, 5'd5, 5'd0, 5'd0, 1'b1, 32'h0000_0123));  // x0 + imm
        send(alu_instr(OP_OR, 5'd6, 5'd0, 5'd0, 1'b0, '0));
        send(li_instr(5'd0, 32'hdead_beef));                             // written stays 0
        send(alu_instr(OP_ADD, 5'd7, 5'd0, 5'd0, 1'b0, '0));             // x0 still zero
        wait_drain();
    endtask

    task automatic test_alu_ops();
        for (int r = 1; r < NUM_REGS; r++) begin
            send(li_instr(5'(r), rand_word()));
        end
        for (int rep = 0; rep < 3; rep++) begin
            for (int op = 0; op <= OP_SLTU; op++) begin
                send(alu_instr(alu_op_e'(op), rand_reg(), rand_reg(), rand_reg(), 1'b0,
                               rand_word()));
                send(alu_instr(alu_op_e'(op), rand_reg(), rand_reg(), rand_reg(), 1'b1,
                               rand_word()));
            end
        end
        wait_drain();
    endtask

    task automatic test_forward_chain();
        logic [4:0] rd;
        logic [4:0] prev1;    // producer one ahead via ex bypass
        logic [4:0] prev2;    // two ahead via wb bypass
        prev1 = 5'd10;
        prev2 = 5'd11;
        for (int i = 0; i < 24; i++) begin
            rd = 5'd12 + 5'(i % 4);
            if (i % 6 == 5) begin
                send(li_instr(rd, rand_word()));                         // imm through bypass
            end else if (i % 2 == 1) begin
                send(alu_instr(rand_alu_op(), rd, prev2, prev1, 1'b0, '0));   // swapped ports
            end else begin
                send(alu_instr(rand_alu_op(), rd, prev1, prev2, 1'b0, '0));
            end
            prev2 = prev1;
            prev1 = rd;
        end
        wait_drain();
    endtask

    task automatic test_branches();
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int rep = 0; rep < 3; rep++) begin
            for (int op = OP_BEQ; op <= OP_BGEU; op++) begin
                for (int pred = 0; pred < 2; pred++) begin
                    rs1 = rand_reg();
                    rs2 = (rand_below(3) == 0) ? rs1 : rand_reg();   // equal now and then
                    send(branch_instr(alu_op_e'(op), rs1, rs2, 1'(pred)));
                    send(li_instr(5'd31, 32'hbad0_0000 + pred));    // dropped on redirect
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_jalr_illegal();
        dec_t d;
        for (int i = 0; i < 4; i++) begin
            send(jalr_instr(rand_reg(), rand_reg(), rand_word(), 1'b0));
            send(li_instr(5'd30, 32'hbad1_0000 + i));
        end
        send(jalr_instr(5'd8, 5'd9, 32'h0000_0041, 1'b1));     // predicted so no redirect
        send(alu_instr(OP_ADD, 5'd8, 5'd8, 5'd0, 1'b1, 32'd4)); // uses the link value
        d         = alu_instr(OP_XOR, 5'd20, 5'd21, 5'd22, 1'b0, '0);
        d.illegal = 1'b1;
        send(d);
        send(alu_instr(OP_OR, 5'd23, 5'd20, 5'd0, 1'b1, '0));  // x20 untouched
        wait_drain();
    endtask

    task automatic test_stalls();
        send(li_instr(5'd1, 32'd5));
        send(li_instr(5'd2, 32'd9));
        send(branch_instr(OP_BLT, 5'd1, 5'd2, 1'b0));    // taken but predicted not taken
        send(li_instr(5'd3, 32'hbad2_0000));
        stall_for(3);                                    // redirect replays high
        send(branch_instr(OP_BEQ, 5'd1, 5'd1, 1'b0));
        stall_for(2);                                    // branch frozen in issue
        send(li_instr(5'd3, 32'hbad2_0001));             // squashed after the stall
        for (int i = 0; i < 40; i++) begin
            send(rand_instr());
            if (rand_below(4) == 0) begin
                stall_for(1 + rand_below(4));
            end
        end
        wait_drain();
    endtask

    initial begin
        seed   = 32'hbcff;
        pc_q   = 32'h0000_1000;
        iss_m  = '0;
        hold_m = '0;
        rst_n <= 1'b0;
        stall <= 1'b0;
        dec   <= '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_alu_ops();
        test_forward_chain();
        test_branches();
        test_jalr_illegal();
        test_stalls();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exe_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_pipe_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  exe_pkg::dec_t            dec_i,
    output logic                     redirect_o,
    output logic [exe_pkg::XLEN-1:0] redirect_pc_o,
    output exe_pkg::retire_t         retire_o
);

    import exe_pkg::*;

    // register file ports
    logic [REG_IDX_W-1:0] rf_raddr_a;
    logic [REG_IDX_W-1:0] rf_raddr_b;
    logic [XLEN-1:0]      rf_rdata_a;
    logic [XLEN-1:0]      rf_rdata_b;
    logic                 rf_we;
    logic [REG_IDX_W-1:0] rf_waddr;
    logic [XLEN-1:0]      rf_wdata;

    // stage to stage
    iss_t                 iss;
    wbk_t                 wbk;
    logic [XLEN-1:0]      byp_ex;
    logic [REG_IDX_W-1:0] byp_ex_rd;
    logic                 byp_ex_we;
    logic                 flush;

    regfile u_regfile (
        .clk       ( clk        ),
        .rst_n_i   ( rst_n_i    ),
        .raddr_a_i ( rf_raddr_a ),
        .raddr_b_i ( rf_raddr_b ),
        .rdata_a_o ( rf_rdata_a ),
        .rdata_b_o ( rf_rdata_b ),
        .we_i      ( rf_we      ),
        .waddr_i   ( rf_waddr   ),
        .wdata_i   ( rf_wdata   )
    );

    issue_stage u_issue (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .stall_i      ( stall_i    ),
        .flush_i      ( flush      ),
        .dec_i        ( dec_i      ),
        .rf_raddr_a_o ( rf_raddr_a ),
        .rf_raddr_b_o ( rf_raddr_b ),
        .rf_rdata_a_i ( rf_rdata_a ),
        .rf_rdata_b_i ( rf_rdata_b ),
        .byp_ex_i     ( byp_ex     ),
        .byp_ex_rd_i  ( byp_ex_rd  ),
        .byp_ex_we_i  ( byp_ex_we  ),
        .byp_wb_i     ( rf_wdata   ),   // wb value doubles as second bypass
        .byp_wb_rd_i  ( rf_waddr   ),
        .byp_wb_we_i  ( rf_we      ),
        .iss_o        ( iss        )
    );

    exe_stage u_exe (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .stall_i       ( stall_i       ),
        .iss_i         ( iss           ),
        .byp_o         ( byp_ex        ),
        .byp_rd_o      ( byp_ex_rd     ),
        .byp_we_o      ( byp_ex_we     ),
        .flush_o       ( flush         ),
        .redirect_o    ( redirect_o    ),
        .redirect_pc_o ( redirect_pc_o ),
        .wbk_o         ( wbk           )
    );

    wb_stage u_wb (
        .wbk_i      ( wbk      ),
        .rf_we_o    ( rf_we    ),
        .rf_waddr_o ( rf_waddr ),
        .rf_wdata_o ( rf_wdata ),
        .retire_o   ( retire_o )
    );

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  exe_pkg::wbk_t                 wbk_i,
    output logic                          rf_we_o,
    output logic [exe_pkg::REG_IDX_W-1:0] rf_waddr_o,
    output logic [exe_pkg::XLEN-1:0]      rf_wdata_o,
    output exe_pkg::retire_t              retire_o
);

    import exe_pkg::*;

    logic [XLEN-1:0] wb_data;

    assign wb_data = result_sel(wbk_i.res_src, wbk_i.alu_res, wbk_i.imm, wbk_i.pc_plus4);

    // illegal and x0 flow through but never write
    assign rf_we_o    = wbk_i.valid & wbk_i.reg_we & ~wbk_i.illegal & (wbk_i.rd_idx != '0);
    assign rf_waddr_o = wbk_i.rd_idx;
    assign rf_wdata_o = wb_data;

    // retire report, one per instruction
    always_comb begin
        retire_o.valid   = wbk_i.valid;
        retire_o.rd_idx  = wbk_i.rd_idx;
        retire_o.data    = wb_data;
        retire_o.written = rf_we_o;
        retire_o.illegal = wbk_i.illegal;
    end

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  exe_pkg::iss_t                 iss_i,
    // execute bypass to issue
    output logic [exe_pkg::XLEN-1:0]      byp_o,
    output logic [exe_pkg::REG_IDX_W-1:0] byp_rd_o,
    output logic                          byp_we_o,
    output logic                          flush_o,
    // fetch side
    output logic                          redirect_o,
    output logic [exe_pkg::XLEN-1:0]      redirect_pc_o,
    output exe_pkg::wbk_t                 wbk_o
);

    import exe_pkg::*;

    logic [XLEN-1:0] opnd_b;
    logic [XLEN-1:0] alu_res;
    logic            alu_taken;
    logic            redirect_now;       // from the current issue slot
    logic [XLEN-1:0] redirect_pc_now;
    logic            redirect_q;         // replayed while stalled
    logic [XLEN-1:0] redirect_pc_q;
    wbk_t            wbk_q;

    assign opnd_b = iss_i.use_imm ? iss_i.imm : iss_i.rs2_val;

    alu u_alu (
        .op_i    ( iss_i.op      ),
        .a_i     ( iss_i.rs1_val ),
        .b_i     ( opnd_b        ),
        .res_o   ( alu_res       ),
        .taken_o ( alu_taken     )
    );

    // bypass carries the final value, imm and link included
    assign byp_o    = result_sel(iss_i.res_src, alu_res, iss_i.imm, iss_i.pc_plus4);
    assign byp_rd_o = iss_i.rd_idx;
    assign byp_we_o = iss_i.valid & iss_i.reg_we & ~iss_i.illegal;

    // ========================================
    // branch / jalr resolution
    // ========================================
    always_comb begin
        redirect_now    = 1'b0;
        redirect_pc_now = iss_i.pc_plus4;
        if (iss_i.valid) begin
            if (iss_i.is_jalr) begin
                redirect_now    = ~iss_i.pred_taken;               // predictor can't know rs1
                redirect_pc_now = {alu_res[XLEN-1:1], 1'b0};       // (rs1+imm) & ~1
            end else if (iss_i.is_branch) begin
                redirect_now    = iss_i.pred_taken ^ alu_taken;
                redirect_pc_now = alu_taken ? iss_i.target_pc : iss_i.pc_plus4;
            end
        end
    end

    assign redirect_o    = stall_i ? redirect_q    : redirect_now;
    assign redirect_pc_o = stall_i ? redirect_pc_q : redirect_pc_now;
    assign flush_o       = redirect_o;   // issue gives stall priority

    // EX/WB register plus redirect pair, all frozen by stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbk_q         <= '0;
            redirect_q    <= 1'b0;
            redirect_pc_q <= '0;
        end else if (!stall_i) begin
            wbk_q.valid    <= iss_i.valid;
            wbk_q.alu_res  <= alu_res;
            wbk_q.imm      <= iss_i.imm;
            wbk_q.pc_plus4 <= iss_i.pc_plus4;
            wbk_q.res_src  <= iss_i.res_src;
            wbk_q.rd_idx   <= iss_i.rd_idx;
            wbk_q.reg_we   <= iss_i.reg_we;
            wbk_q.illegal  <= iss_i.illegal;
            redirect_q     <= redirect_now;
            redirect_pc_q  <= redirect_pc_now;
        end
    end

    // held entry must not retire twice
    always_comb begin
        wbk_o       = wbk_q;
        wbk_o.valid = wbk_q.valid & ~stall_i;
    end

    a_redirect_needs_valid : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (!iss_i.valid && !stall_i) |-> !redirect_o
    ) else $error("exe: redirect with empty issue slot");

    // the younger instruction behind a redirect is squashed in issue
    a_flush_bubble : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (redirect_o && !stall_i) |=> !iss_i.valid
    ) else $error("exe: wrong-path instruction reached execute");

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  exe_pkg::dec_t                 dec_i,
    // register file read side
    output logic [exe_pkg::REG_IDX_W-1:0] rf_raddr_a_o,
    output logic [exe_pkg::REG_IDX_W-1:0] rf_raddr_b_o,
    input  logic [exe_pkg::XLEN-1:0]      rf_rdata_a_i,
    input  logic [exe_pkg::XLEN-1:0]      rf_rdata_b_i,
    // forwarding sources
    input  logic [exe_pkg::XLEN-1:0]      byp_ex_i,
    input  logic [exe_pkg::REG_IDX_W-1:0] byp_ex_rd_i,
    input  logic                          byp_ex_we_i,
    input  logic [exe_pkg::XLEN-1:0]      byp_wb_i,
    input  logic [exe_pkg::REG_IDX_W-1:0] byp_wb_rd_i,
    input  logic                          byp_wb_we_i,
    output exe_pkg::iss_t                 iss_o
);

    import exe_pkg::*;

    iss_t iss_d;
    iss_t iss_q;

    // youngest producer wins, x0 always zero
    function automatic logic [XLEN-1:0] fwd_operand(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      rf_val
    );
        if (idx == '0) begin
            return '0;
        end else if (byp_ex_we_i && (byp_ex_rd_i == idx)) begin
            return byp_ex_i;      // instruction one ahead
        end else if (byp_wb_we_i && (byp_wb_rd_i == idx)) begin
            return byp_wb_i;      // two ahead, not yet in the array
        end
        return rf_val;
    endfunction

    assign rf_raddr_a_o = dec_i.rs1_idx;
    assign rf_raddr_b_o = dec_i.rs2_idx;

    // ========================================
    // operand resolve
    // ========================================
    always_comb begin
        iss_d.valid      = dec_i.valid;
        iss_d.op         = dec_i.op;
        iss_d.rs1_val    = fwd_operand(dec_i.rs1_idx, rf_rdata_a_i);
        iss_d.rs2_val    = fwd_operand(dec_i.rs2_idx, rf_rdata_b_i);
        iss_d.imm        = dec_i.imm;
        iss_d.use_imm    = dec_i.use_imm;
        iss_d.pc_plus4   = dec_i.pc_plus4;
        iss_d.is_branch  = dec_i.is_branch;
        iss_d.is_jalr    = dec_i.is_jalr;
        iss_d.pred_taken = dec_i.pred_taken;
        iss_d.target_pc  = dec_i.target_pc;
        iss_d.res_src    = dec_i.res_src;
        iss_d.rd_idx     = dec_i.rd_idx;
        iss_d.reg_we     = dec_i.reg_we;
        iss_d.illegal    = dec_i.illegal;
    end

    // ID/EX register, stall beats flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_q <= '0;
        end else if (!stall_i) begin
            if (flush_i) begin
                iss_q <= '0;      // wrong-path slot becomes a bubble
            end else begin
                iss_q <= iss_d;
            end
        end
    end

    assign iss_o = iss_q;

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exe_pkg::alu_op_e          op_i,
    input  logic [exe_pkg::XLEN-1:0]  a_i,
    input  logic [exe_pkg::XLEN-1:0]  b_i,
    output logic [exe_pkg::XLEN-1:0]  res_o,
    output logic                      taken_o   // branch condition met
);

    import exe_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       is_branch_op;

    assign shamt = b_i[4:0];                    // rv32 uses low five bits
    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    assign is_branch_op = op_i inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

    // ========================================
    // result and branch flag
    // ========================================
    always_comb begin
        res_o   = '0;       // branch codes leave zero here
        taken_o = 1'b0;
        case (op_i)
            OP_ADD:  res_o = a_i + b_i;
            OP_SUB:  res_o = a_i - b_i;
            OP_AND:  res_o = a_i & b_i;
            OP_OR:   res_o = a_i | b_i;
            OP_XOR:  res_o = a_i ^ b_i;
            OP_SLL:  res_o = a_i << shamt;
            OP_SRL:  res_o = a_i >> shamt;
            OP_SRA:  res_o = $signed(a_i) >>> shamt;    // sign fill
            OP_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
            OP_BEQ:  taken_o = eq;
            OP_BNE:  taken_o = ~eq;
            OP_BLT:  taken_o = lt_s;
            OP_BGE:  taken_o = ~lt_s;
            OP_BLTU: taken_o = lt_u;
            OP_BGEU: taken_o = ~lt_u;
            default: res_o = '0;
        endcase
    end

    // no clock in here, so a deferred check once the inputs settle
    always_comb begin
        a_taken_only_branch : assert final (is_branch_op || !taken_o)
            else $error("alu: taken_o high for op %s", op_i.name());
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [exe_pkg::REG_IDX_W-1:0] raddr_a_i,
    input  logic [exe_pkg::REG_IDX_W-1:0] raddr_b_i,
    output logic [exe_pkg::XLEN-1:0]      rdata_a_o,
    output logic [exe_pkg::XLEN-1:0]      rdata_b_o,
    input  logic                          we_i,
    input  logic [exe_pkg::REG_IDX_W-1:0] waddr_i,
    input  logic [exe_pkg::XLEN-1:0]      wdata_i
);

    import exe_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];   // x0 is never written

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // async read, same-cycle write is covered by wb forwarding
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

    // wb stage must already have dropped rd=0 writes
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(we_i && (waddr_i == '0))
    ) else $error("regfile: write enable with waddr 0");

endmodule

`default_nettype wire

// ==== exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int XLEN      = 32;             // datapath width
    localparam int REG_IDX_W = 5;              // x0..x31
    localparam int NUM_REGS  = 2**REG_IDX_W;
    localparam int OP_W      = 5;              // alu opcode width
    localparam int RES_W     = 2;              // write-back select width

    // alu opcodes, branch compares live in the upper group
    typedef enum logic [OP_W-1:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } alu_op_e;

    // write-back value source
    typedef enum logic [RES_W-1:0] {
        RES_ALU,
        RES_IMM,   // lui style
        RES_PC4    // link value for jal/jalr
    } res_src_e;

    // ========================================
    // stage bundles
    // ========================================
    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [XLEN-1:0]      imm;         // already sign extended
        logic                 use_imm;     // operand b = imm
        logic [XLEN-1:0]      pc_plus4;
        logic                 is_branch;
        logic                 is_jalr;
        logic                 pred_taken;  // static predictor decision
        logic [XLEN-1:0]      target_pc;   // branch target
        res_src_e             res_src;
        logic [REG_IDX_W-1:0] rd_idx;
        logic                 reg_we;
        logic                 illegal;
    } dec_t;

    // same control as dec_t, register indices replaced by operand values
    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic [XLEN-1:0]      pc_plus4;
        logic                 is_branch;
        logic                 is_jalr;
        logic                 pred_taken;
        logic [XLEN-1:0]      target_pc;
        res_src_e             res_src;
        logic [REG_IDX_W-1:0] rd_idx;
        logic                 reg_we;
        logic                 illegal;
    } iss_t;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      alu_res;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      pc_plus4;
        res_src_e             res_src;
        logic [REG_IDX_W-1:0] rd_idx;
        logic                 reg_we;
        logic                 illegal;
    } wbk_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd_idx;
        logic [XLEN-1:0]      data;
        logic                 written;     // register file actually updated
        logic                 illegal;
    } retire_t;

    // write-back mux, shared by the execute bypass and the wb stage
    function automatic logic [XLEN-1:0] result_sel(
        input res_src_e        src,
        input logic [XLEN-1:0] alu_res,
        input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] pc_plus4
    );
        case (src)
            RES_IMM: return imm;
            RES_PC4: return pc_plus4;
            default: return alu_res;
        endcase
    endfunction

endpackage

`default_nettype wire
